//--- logic/aluDecoder.sv
/*
 * ALU operation decode from the latched funct3, funct7 bit 5 and opcode.
 * The step decoder uses the result only in the execute states.
 */
module aluDecoder
    import cpuCtrlPkg::*;
(
    seqStatus_if.reader i_seq,
    output logic [2:0]  o_aluOp
);

    logic subSel;

    // sub only for R-type with funct7[5] set; addi ignores that bit
    assign subSel = (i_seq.opcode == OP_RTYPE) && i_seq.funct7b5;

    always_comb
    begin
        case (i_seq.funct3)
            3'b000:  o_aluOp = subSel ? ALU_SUB : ALU_ADD;
            3'b010:  o_aluOp = ALU_SLT;
            3'b100:  o_aluOp = ALU_XOR;
            3'b110:  o_aluOp = ALU_OR;
            3'b111:  o_aluOp = ALU_AND;
            // shifts and sltu not supported
            default: o_aluOp = ALU_ADD;
        endcase
    end

endmodule

//--- logic/controlUnit.sv
/*
 * Top level of the multicycle RV32I control unit.
 * Connects sequencer and decoders, presents control lines as plain ports.
 */
module controlUnit
    import cpuCtrlPkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic [INSTR_W-1:0] i_memReadData,
    input  logic               i_zero,
    output logic               o_pcWrite,
    output logic               o_adrSrc,
    output logic               o_memWrite,
    output logic               o_irWrite,
    output logic               o_regWrite,
    output logic [1:0]         o_resultSrc,
    output logic [1:0]         o_aluSrcA,
    output logic [1:0]         o_aluSrcB,
    output logic [2:0]         o_aluControl,
    output logic [2:0]         o_immSrc
);

    // decoded ALU op, used by the step decoder in execute
    logic [2:0] aluOp;

    seqStatus_if seqStatus ();
    ctrlBus_if   ctrlBus ();

    // state register and field latch
    mainSequencer uSeq (
        .clk           (clk),
        .resetn        (resetn),
        .i_memReadData (i_memReadData),
        .o_seq         (seqStatus.source)
    );

    aluDecoder uAluDec (
        .i_seq   (seqStatus.reader),
        .o_aluOp (aluOp)
    );

    immDecoder uImmDec (
        .i_seq    (seqStatus.reader),
        .o_immSrc (o_immSrc)
    );

    // per-state control lines
    stepDecoder uStepDec (
        .i_seq   (seqStatus.reader),
        .i_zero  (i_zero),
        .i_aluOp (aluOp),
        .o_ctrl  (ctrlBus.driver)
    );

    // break the control bus out to ports
    assign o_pcWrite    = ctrlBus.pcWrite;
    assign o_adrSrc     = ctrlBus.adrSrc;
    assign o_memWrite   = ctrlBus.memWrite;
    assign o_irWrite    = ctrlBus.irWrite;
    assign o_regWrite   = ctrlBus.regWrite;
    assign o_resultSrc  = ctrlBus.resultSrc;
    assign o_aluSrcA    = ctrlBus.aluSrcA;
    assign o_aluSrcB    = ctrlBus.aluSrcB;
    assign o_aluControl = ctrlBus.aluControl;

endmodule

//--- logic/cpuCtrlPkg.sv
/*
 * Shared encodings for the multicycle RV32I control unit.
 * State codes, opcodes, ALU and immediate formats, datapath select codes.
 */
package cpuCtrlPkg;

    // instruction word
    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;

    // FSM state codes
    localparam int STATE_W = 4;

    localparam logic [STATE_W-1:0] ST_RESET     = 4'd0;
    localparam logic [STATE_W-1:0] ST_FETCH     = 4'd1;
    localparam logic [STATE_W-1:0] ST_DECODE    = 4'd2;
    localparam logic [STATE_W-1:0] ST_MEM_ADDR  = 4'd3;
    localparam logic [STATE_W-1:0] ST_MEM_READ  = 4'd4;
    localparam logic [STATE_W-1:0] ST_MEM_WB    = 4'd5;
    localparam logic [STATE_W-1:0] ST_MEM_WRITE = 4'd6;
    localparam logic [STATE_W-1:0] ST_EXEC_R    = 4'd7;
    localparam logic [STATE_W-1:0] ST_ALU_WB    = 4'd8;
    localparam logic [STATE_W-1:0] ST_EXEC_I    = 4'd9;
    localparam logic [STATE_W-1:0] ST_JAL       = 4'd10;
    localparam logic [STATE_W-1:0] ST_BEQ       = 4'd11;
    localparam logic [STATE_W-1:0] ST_LUI       = 4'd12;
    localparam logic [STATE_W-1:0] ST_ERROR     = 4'd13;

    // supported opcodes
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_RTYPE  = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_ITYPE  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    // all-zero word treated as nop
    localparam logic [OPCODE_W-1:0] OP_NOP    = 7'b0000000;

    // ALU operations
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_AND = 3'b010;
    localparam logic [2:0] ALU_OR  = 3'b011;
    localparam logic [2:0] ALU_XOR = 3'b100;
    localparam logic [2:0] ALU_SLT = 3'b101;

    // immediate extension formats
    localparam logic [2:0] IMM_I = 3'b000;
    localparam logic [2:0] IMM_S = 3'b001;
    localparam logic [2:0] IMM_B = 3'b010;
    localparam logic [2:0] IMM_J = 3'b011;
    localparam logic [2:0] IMM_U = 3'b100;

    // ALU operand A mux
    localparam logic [1:0] SRCA_PC    = 2'b00;
    localparam logic [1:0] SRCA_OLDPC = 2'b01;
    localparam logic [1:0] SRCA_REG   = 2'b10;
    localparam logic [1:0] SRCA_ZERO  = 2'b11;

    // ALU operand B mux
    localparam logic [1:0] SRCB_REG  = 2'b00;
    localparam logic [1:0] SRCB_IMM  = 2'b01;
    localparam logic [1:0] SRCB_FOUR = 2'b10;

    // result bus mux
    localparam logic [1:0] RES_ALUOUT = 2'b00;
    localparam logic [1:0] RES_DATA   = 2'b01;
    localparam logic [1:0] RES_ALU    = 2'b10;

endpackage

//--- logic/ctrlBus_if.sv
/*
 * Datapath control lines from the step decoder to the top level.
 * One level per state, no handshake.
 */
interface ctrlBus_if;

    // PC register enable
    logic       pcWrite;
    // memory address from result bus instead of PC
    logic       adrSrc;
    logic       memWrite;
    // instruction register load
    logic       irWrite;
    logic       regWrite;
    // mux selects
    logic [1:0] resultSrc;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [2:0] aluControl;

    modport driver (
        output pcWrite, adrSrc, memWrite, irWrite, regWrite,
        output resultSrc, aluSrcA, aluSrcB, aluControl
    );

    modport sink (
        input pcWrite, adrSrc, memWrite, irWrite, regWrite,
        input resultSrc, aluSrcA, aluSrcB, aluControl
    );

endinterface

//--- logic/immDecoder.sv
/*
 * Immediate format select from the latched opcode.
 */
module immDecoder
    import cpuCtrlPkg::*;
(
    seqStatus_if.reader i_seq,
    output logic [2:0]  o_immSrc
);

    always_comb
    begin
        case (i_seq.opcode)
            OP_STORE:  o_immSrc = IMM_S;
            OP_BRANCH: o_immSrc = IMM_B;
            OP_JAL:    o_immSrc = IMM_J;
            OP_LUI:    o_immSrc = IMM_U;
            // loads, I-type ALU and everything else
            default:   o_immSrc = IMM_I;
        endcase
    end

endmodule

//--- logic/mainSequencer.sv
/*
 * State register and next-state logic of the multicycle control FSM.
 * Latches opcode, funct3 and funct7 bit 5 from memory read data in fetch.
 */
module mainSequencer
    import cpuCtrlPkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic [INSTR_W-1:0] i_memReadData,
    seqStatus_if.source        o_seq
);

    logic [STATE_W-1:0]  state;
    logic [STATE_W-1:0]  nextState;
    logic [OPCODE_W-1:0] opcode;
    logic [2:0]          funct3;
    logic                funct7b5;

    // state register, reset held while resetn is high
    always_ff @(posedge clk)
    begin
        if (resetn)
            state <= ST_RESET;
        else
            state <= nextState;
    end

    // instruction fields, captured at the end of fetch
    always_ff @(posedge clk)
    begin
        if (resetn)
        begin
            opcode   <= OP_NOP;
            funct3   <= 3'b000;
            funct7b5 <= 1'b0;
        end
        else if (state == ST_FETCH)
        begin
            opcode   <= i_memReadData[6:0];
            funct3   <= i_memReadData[14:12];
            funct7b5 <= i_memReadData[30];
        end
    end

    // next-state logic
    always_comb
    begin
        nextState = ST_RESET;
        case (state)
            ST_RESET:
                nextState = ST_FETCH;
            ST_FETCH:
                nextState = ST_DECODE;
            ST_DECODE:
            begin
                // branch on the opcode latched in fetch
                case (opcode)
                    OP_LOAD,
                    OP_STORE:  nextState = ST_MEM_ADDR;
                    OP_RTYPE:  nextState = ST_EXEC_R;
                    OP_ITYPE:  nextState = ST_EXEC_I;
                    OP_JAL:    nextState = ST_JAL;
                    OP_BRANCH: nextState = ST_BEQ;
                    OP_LUI:    nextState = ST_LUI;
                    // nop skips straight back to fetch
                    OP_NOP:    nextState = ST_FETCH;
                    default:   nextState = ST_ERROR;
                endcase
            end
            ST_MEM_ADDR:
            begin
                // only loads and stores reach here
                if (opcode == OP_LOAD)
                    nextState = ST_MEM_READ;
                else
                    nextState = ST_MEM_WRITE;
            end
            ST_MEM_READ:
                nextState = ST_MEM_WB;
            ST_EXEC_R,
            ST_EXEC_I,
            ST_JAL,
            ST_LUI:
                nextState = ST_ALU_WB;
            ST_MEM_WB,
            ST_MEM_WRITE,
            ST_ALU_WB,
            ST_BEQ:
                nextState = ST_FETCH;
            // stuck until reset
            ST_ERROR:
                nextState = ST_ERROR;
            default:
                nextState = ST_RESET;
        endcase
    end

    // status out to the decoders
    assign o_seq.state    = state;
    assign o_seq.opcode   = opcode;
    assign o_seq.funct3   = funct3;
    assign o_seq.funct7b5 = funct7b5;

endmodule

//--- logic/seqStatus_if.sv
/*
 * Sequencer status: current FSM state and the instruction fields
 * latched during fetch, shared by the decoders.
 */
interface seqStatus_if
    import cpuCtrlPkg::*;
;

    logic [STATE_W-1:0]  state;
    logic [OPCODE_W-1:0] opcode;
    logic [2:0]          funct3;
    // R-type add/sub select
    logic                funct7b5;

    modport source (
        output state, opcode, funct3, funct7b5
    );

    modport reader (
        input state, opcode, funct3, funct7b5
    );

endinterface

//--- logic/stepDecoder.sv
/*
 * Moore output table of the control FSM.
 * Drives datapath selects and enables from the current state only.
 */
module stepDecoder
    import cpuCtrlPkg::*;
(
    seqStatus_if.reader i_seq,
    input  logic        i_zero,
    input  logic [2:0]  i_aluOp,
    ctrlBus_if.driver   o_ctrl
);

    always_comb
    begin
        // idle values: nothing written, ALUOut on result bus, add
        o_ctrl.pcWrite    = 1'b0;
        o_ctrl.adrSrc     = 1'b0;
        o_ctrl.memWrite   = 1'b0;
        o_ctrl.irWrite    = 1'b0;
        o_ctrl.regWrite   = 1'b0;
        o_ctrl.resultSrc  = RES_ALUOUT;
        o_ctrl.aluSrcA    = SRCA_PC;
        o_ctrl.aluSrcB    = SRCB_REG;
        o_ctrl.aluControl = ALU_ADD;

        case (i_seq.state)
            ST_FETCH:
            begin
                // load IR and write PC+4 straight back through the ALU
                o_ctrl.pcWrite   = 1'b1;
                o_ctrl.irWrite   = 1'b1;
                o_ctrl.resultSrc = RES_ALU;
                o_ctrl.aluSrcA   = SRCA_PC;
                o_ctrl.aluSrcB   = SRCB_FOUR;
            end
            ST_DECODE:
            begin
                // oldPC + imm, branch/jump target into ALUOut
                o_ctrl.aluSrcA = SRCA_OLDPC;
                o_ctrl.aluSrcB = SRCB_IMM;
            end
            ST_MEM_ADDR:
            begin
                // rs1 + offset
                o_ctrl.aluSrcA = SRCA_REG;
                o_ctrl.aluSrcB = SRCB_IMM;
            end
            ST_MEM_READ:
                o_ctrl.adrSrc = 1'b1;
            ST_MEM_WB:
            begin
                // load data into rd
                o_ctrl.resultSrc = RES_DATA;
                o_ctrl.regWrite  = 1'b1;
            end
            ST_MEM_WRITE:
            begin
                o_ctrl.adrSrc   = 1'b1;
                o_ctrl.memWrite = 1'b1;
            end
            ST_EXEC_R:
            begin
                o_ctrl.aluSrcA    = SRCA_REG;
                o_ctrl.aluSrcB    = SRCB_REG;
                o_ctrl.aluControl = i_aluOp;
            end
            ST_EXEC_I:
            begin
                o_ctrl.aluSrcA    = SRCA_REG;
                o_ctrl.aluSrcB    = SRCB_IMM;
                o_ctrl.aluControl = i_aluOp;
            end
            ST_ALU_WB:
                o_ctrl.regWrite = 1'b1;
            ST_JAL:
            begin
                // jump target from decode goes to PC, ALU makes the link value
                o_ctrl.pcWrite = 1'b1;
                o_ctrl.aluSrcA = SRCA_OLDPC;
                o_ctrl.aluSrcB = SRCB_FOUR;
            end
            ST_BEQ:
            begin
                // compare by subtraction, take branch on zero
                o_ctrl.aluSrcA    = SRCA_REG;
                o_ctrl.aluSrcB    = SRCB_REG;
                o_ctrl.aluControl = ALU_SUB;
                o_ctrl.pcWrite    = i_zero;
            end
            ST_LUI:
            begin
                // 0 + upper immediate
                o_ctrl.aluSrcA = SRCA_ZERO;
                o_ctrl.aluSrcB = SRCB_IMM;
            end
            // reset, error and unused codes keep idle values
            default:
            begin
            end
        endcase
    end

endmodule

//--- src.f
logic/cpuCtrlPkg.sv
logic/ctrlBus_if.sv
logic/seqStatus_if.sv
logic/mainSequencer.sv
logic/stepDecoder.sv
logic/aluDecoder.sv
logic/immDecoder.sv
logic/controlUnit.sv
verification/clockGen.sv
verification/controlUnit_tb.sv

//--- verification/clockGen.sv
/*
 * Free-running testbench clock, period of 100 time units.
 */
module clockGen (
    output logic o_clk
);

    // low for the first half period, rising edge at 50
    initial
    begin
        o_clk = 1'b0;
        forever
            #50 o_clk = ~o_clk;
    end

endmodule

//--- verification/controlUnit_tb.sv
/*
 * Table-driven testbench for the multicycle control unit.
 * Feeds one instruction word per fetch and checks cycles, pulses and decodes.
 */
module controlUnit_tb
    import cpuCtrlPkg::*;
;

    logic               clk;
    logic               resetn;
    logic [INSTR_W-1:0] memReadData;
    logic               zero;
    logic               pcWrite;
    logic               adrSrc;
    logic               memWrite;
    logic               irWrite;
    logic               regWrite;
    logic [1:0]         resultSrc;
    logic [1:0]         aluSrcA;
    logic [1:0]         aluSrcB;
    logic [2:0]         aluControl;
    logic [2:0]         immSrc;

    int mismatchCount;
    int timeoutCount;

    // stimulus table with one entry per instruction
    string               rowName[$];
    logic [OPCODE_W-1:0] rowOp[$];
    logic [2:0]          rowF3[$];
    logic                rowF7b5[$];
    logic                rowZero[$];
    int                  rowCycles[$];
    logic                rowReg[$];
    logic                rowMem[$];
    int                  rowPc[$];
    logic [2:0]          rowAlu[$];
    logic [2:0]          rowImm[$];

    clockGen clkSrc (
        .o_clk (clk)
    );

    controlUnit dut (
        .clk           (clk),
        .resetn        (resetn),
        .i_memReadData (memReadData),
        .i_zero        (zero),
        .o_pcWrite     (pcWrite),
        .o_adrSrc      (adrSrc),
        .o_memWrite    (memWrite),
        .o_irWrite     (irWrite),
        .o_regWrite    (regWrite),
        .o_resultSrc   (resultSrc),
        .o_aluSrcA     (aluSrcA),
        .o_aluSrcB     (aluSrcB),
        .o_aluControl  (aluControl),
        .o_immSrc      (immSrc)
    );

    task automatic checkCount(input string name, input string what, input int exp,
                              input int act);
        if (exp != act)
        begin
            mismatchCount++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act)
        begin
            mismatchCount++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // 2-bit mux selects
    task automatic checkSelect(input string name, input string what, input logic [1:0] exp,
                               input logic [1:0] act);
        if (exp !== act)
        begin
            mismatchCount++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic checkAluOp(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act)
        begin
            mismatchCount++;
            $display("MISMATCH %s aluControl: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkImmSrc(input string name, input logic [2:0] exp,
                               input logic [2:0] act);
        if (exp !== act)
        begin
            mismatchCount++;
            $display("MISMATCH %s immSrc: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic addRow(input string name, input logic [OPCODE_W-1:0] op,
                          input logic [2:0] f3, input logic f7b5, input logic z,
                          input int cycles, input logic regWr, input logic mem, input int pc,
                          input logic [2:0] alu, input logic [2:0] imm);
        rowName.push_back(name);
        rowOp.push_back(op);
        rowF3.push_back(f3);
        rowF7b5.push_back(f7b5);
        rowZero.push_back(z);
        rowCycles.push_back(cycles);
        rowReg.push_back(regWr);
        rowMem.push_back(mem);
        rowPc.push_back(pc);
        rowAlu.push_back(alu);
        rowImm.push_back(imm);
    endtask

    task automatic loadTable();
        // name, opcode, funct3, f7b5, zero, cycles, reg, mem, pc pulses, exec ALU, imm
        addRow("lw",   OP_LOAD,   3'b010, 1'b0, 1'b0, 5, 1'b1, 1'b0, 1, ALU_ADD, IMM_I);
        addRow("sw",   OP_STORE,  3'b010, 1'b0, 1'b0, 4, 1'b0, 1'b1, 1, ALU_ADD, IMM_S);
        // zero high outside beq must not move the PC
        addRow("add",  OP_RTYPE,  3'b000, 1'b0, 1'b1, 4, 1'b1, 1'b0, 1, ALU_ADD, IMM_I);
        addRow("sub",  OP_RTYPE,  3'b000, 1'b1, 1'b0, 4, 1'b1, 1'b0, 1, ALU_SUB, IMM_I);
        addRow("slt",  OP_RTYPE,  3'b010, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_SLT, IMM_I);
        addRow("xor",  OP_RTYPE,  3'b100, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_XOR, IMM_I);
        addRow("or",   OP_RTYPE,  3'b110, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_OR,  IMM_I);
        addRow("and",  OP_RTYPE,  3'b111, 1'b1, 1'b0, 4, 1'b1, 1'b0, 1, ALU_AND, IMM_I);
        // unsupported funct3 falls back to add
        addRow("sll",  OP_RTYPE,  3'b001, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_ADD, IMM_I);
        // bit 30 set on addi is still add
        addRow("addi", OP_ITYPE,  3'b000, 1'b1, 1'b0, 4, 1'b1, 1'b0, 1, ALU_ADD, IMM_I);
        addRow("slti", OP_ITYPE,  3'b010, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_SLT, IMM_I);
        addRow("xori", OP_ITYPE,  3'b100, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_XOR, IMM_I);
        addRow("ori",  OP_ITYPE,  3'b110, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_OR,  IMM_I);
        addRow("andi", OP_ITYPE,  3'b111, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_AND, IMM_I);
        addRow("jal",  OP_JAL,    3'b110, 1'b0, 1'b0, 4, 1'b1, 1'b0, 2, ALU_ADD, IMM_J);
        addRow("beqT", OP_BRANCH, 3'b000, 1'b0, 1'b1, 3, 1'b0, 1'b0, 2, ALU_SUB, IMM_B);
        addRow("beqN", OP_BRANCH, 3'b000, 1'b0, 1'b0, 3, 1'b0, 1'b0, 1, ALU_SUB, IMM_B);
        addRow("lui",  OP_LUI,    3'b101, 1'b0, 1'b0, 4, 1'b1, 1'b0, 1, ALU_ADD, IMM_U);
        // no execute cycle so the ALU code is not compared
        addRow("nop",  OP_NOP,    3'b000, 1'b0, 1'b0, 2, 1'b0, 1'b0, 1, ALU_ADD, IMM_I);
    endtask

    // bounded wait on falling edges for the next fetch cycle
    task automatic waitForFetch(input int limit, output bit found, output int waited);
        found  = 1'b0;
        waited = 0;
        while (!found && waited < limit)
        begin
            @(negedge clk);
            waited++;
            if (irWrite === 1'b1)
                found = 1'b1;
        end
    endtask

    task automatic checkAllLow(input string name);
        checkFlag(name, "pcWrite", 1'b0, pcWrite);
        checkFlag(name, "adrSrc", 1'b0, adrSrc);
        checkFlag(name, "memWrite", 1'b0, memWrite);
        checkFlag(name, "irWrite", 1'b0, irWrite);
        checkFlag(name, "regWrite", 1'b0, regWrite);
        checkSelect(name, "resultSrc", 2'b00, resultSrc);
        checkSelect(name, "aluSrcA", 2'b00, aluSrcA);
        checkSelect(name, "aluSrcB", 2'b00, aluSrcB);
        checkAluOp(name, 3'b000, aluControl);
        checkImmSrc(name, 3'b000, immSrc);
    endtask

    // reset held for 16 rising edges and outputs checked on each falling edge
    task automatic applyReset();
        int i;
        resetn = 1'b1;
        for (i = 0; i < 16; i++)
        begin
            @(negedge clk);
            checkAllLow("reset");
        end
        resetn = 1'b0;
    endtask

    task automatic checkStartup(input string name, output bit found);
        int waited;
        waitForFetch(10, found, waited);
        if (!found)
        begin
            timeoutCount++;
            $display("timeout: %s never reached fetch after reset release", name);
        end
        else
        begin
            // release cycle is ST_RESET and counts as cycle one
            checkCount(name, "first fetch cycle", 2, waited + 1);
            checkFlag(name, "pcWrite in fetch", 1'b1, pcWrite);
            checkSelect(name, "aluSrcB in fetch", SRCB_FOUR, aluSrcB);
        end
    endtask

    // entered on the falling edge of a fetch cycle and left on the next one
    task automatic runRow(input int r, output bit ok);
        logic [INSTR_W-1:0] word;
        int                 cycles;
        int                 guard;
        int                 pcCount;
        logic               regSeen;
        logic               memSeen;
        logic               execPc;
        logic [1:0]         execSrcA;
        logic [2:0]         execAlu;
        logic [2:0]         immSeen;
        bit                 done;
        word          = $urandom;
        word[6:0]     = rowOp[r];
        word[14:12]   = rowF3[r];
        word[30]      = rowF7b5[r];
        cycles        = 1;
        guard         = 0;
        done          = 1'b0;
        pcCount       = pcWrite ? 1 : 0;
        regSeen       = regWrite;
        memSeen       = memWrite;
        execPc        = 1'b0;
        execSrcA      = SRCA_PC;
        execAlu       = ALU_ADD;
        immSeen       = 3'b000;
        memReadData   = word;
        zero          = rowZero[r];
        while (!done && guard < 20)
        begin
            @(negedge clk);
            guard++;
            if (irWrite === 1'b1)
                done = 1'b1;
            else
            begin
                cycles++;
                regSeen = regSeen | regWrite;
                memSeen = memSeen | memWrite;
                if (pcWrite === 1'b1)
                    pcCount++;
                // decode cycle with fields already latched
                if (cycles == 2)
                    immSeen = immSrc;
                // execute or first memory cycle
                if (cycles == 3)
                begin
                    execAlu  = aluControl;
                    execSrcA = aluSrcA;
                    execPc   = pcWrite;
                end
            end
        end
        ok = done;
        if (!done)
        begin
            timeoutCount++;
            $display("timeout: test %s never returned to fetch", rowName[r]);
        end
        else
        begin
            checkCount(rowName[r], "cycles", rowCycles[r], cycles);
            checkFlag(rowName[r], "regWrite seen", rowReg[r], regSeen);
            checkFlag(rowName[r], "memWrite seen", rowMem[r], memSeen);
            checkCount(rowName[r], "pcWrite pulses", rowPc[r], pcCount);
            if (rowCycles[r] > 2)
                checkAluOp(rowName[r], rowAlu[r], execAlu);
            checkImmSrc(rowName[r], rowImm[r], immSeen);
            if (rowOp[r] == OP_BRANCH)
                checkFlag(rowName[r], "pcWrite in beq", rowZero[r], execPc);
            if (rowOp[r] == OP_LUI)
                checkSelect(rowName[r], "aluSrcA in execute", SRCA_ZERO, execSrcA);
        end
    endtask

    // after an illegal opcode no fetch may follow until reset
    task automatic runIllegal();
        logic [INSTR_W-1:0] word;
        bit                 found;
        int                 waited;
        word        = $urandom;
        word[6:0]   = 7'b1111111;
        memReadData = word;
        zero        = 1'b0;
        waitForFetch(20, found, waited);
        if (found)
        begin
            mismatchCount++;
            $display("illegal opcode did not stop the FSM, fetch came back after %0d cycles",
                     waited);
        end
        else
            checkAllLow("illegal");
    endtask

    initial
    begin
        int          r;
        int unsigned seed;
        bit          started;
        bit          ok;
        mismatchCount = 0;
        timeoutCount  = 0;
        resetn        = 1'b1;
        memReadData   = '0;
        zero          = 1'b0;
        seed          = 32'h79922b3e;
        void'($urandom(seed));
        loadTable();

        applyReset();
        checkStartup("first reset", started);
        ok = started;
        for (r = 0; r < rowName.size() && ok; r++)
            runRow(r, ok);
        if (ok)
            runIllegal();

        // recovery from the error state
        applyReset();
        checkStartup("second reset", started);
        if (started)
            runRow(2, ok);

        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
